// File: common/iu_pkg.sv
// Integer unit shared definitions
package iu_pkg;

  localparam int XLEN      = 32;
  localparam int PREG_W    = 6;
  localparam int FUNC_W    = 4;
  localparam int DIV_STEPS = 32;
  localparam int DIV_CNT_W = $clog2(DIV_STEPS);

  // Execution unit select
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2
  } iu_unit_e;

  typedef enum logic [FUNC_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } iu_alu_op_e;

  // MULH is signed x signed, MULHU unsigned x unsigned
  typedef enum logic [FUNC_W-1:0] {
    MUL_MUL   = 4'd0,
    MUL_MULH  = 4'd1,
    MUL_MULHU = 4'd2
  } iu_mul_op_e;

  typedef enum logic [FUNC_W-1:0] {
    DIV_DIV  = 4'd0,
    DIV_DIVU = 4'd1,
    DIV_REM  = 4'd2,
    DIV_REMU = 4'd3
  } iu_div_op_e;

  // Operation from the issue stage
  typedef struct packed {
    logic              vld;
    iu_unit_e          unit;
    logic [FUNC_W-1:0] func;
    logic [XLEN-1:0]   src0;
    logic [XLEN-1:0]   src1;
    logic [PREG_W-1:0] dst_preg;
  } iu_issue_t;

  // Finished result, used for forwarding, ex2 and write-back
  typedef struct packed {
    logic              vld;
    logic [PREG_W-1:0] preg;
    logic [XLEN-1:0]   data;
  } iu_rslt_t;

endpackage

// File: verilog/iu_alu.sv
// Single-cycle ALU
`timescale 1ns/100ps

module iu_alu (
  input  logic [iu_pkg::FUNC_W-1:0] func,
  input  logic [iu_pkg::XLEN-1:0]   src0,
  input  logic [iu_pkg::XLEN-1:0]   src1,
  output logic [iu_pkg::XLEN-1:0]   rslt
);

  import iu_pkg::*;

  iu_alu_op_e op;
  logic [4:0] shamt;

  assign op = iu_alu_op_e'(func);

  // RV32 shifts only look at the low five bits
  assign shamt = src1[4:0];

  always_comb begin
    case (op)
      ALU_ADD: begin
        rslt = src0 + src1;
      end
      ALU_SUB: begin
        rslt = src0 - src1;
      end
      ALU_AND: begin
        rslt = src0 & src1;
      end
      ALU_OR: begin
        rslt = src0 | src1;
      end
      ALU_XOR: begin
        rslt = src0 ^ src1;
      end
      ALU_SLL: begin
        rslt = src0 << shamt;
      end
      ALU_SRL: begin
        rslt = src0 >> shamt;
      end
      ALU_SRA: begin
        rslt = $signed(src0) >>> shamt;
      end
      ALU_SLT: begin
        rslt = {{(XLEN-1){1'b0}}, $signed(src0) < $signed(src1)};
      end
      ALU_SLTU: begin
        rslt = {{(XLEN-1){1'b0}}, src0 < src1};
      end
      default: begin
        rslt = '0;
      end
    endcase
  end

endmodule

// File: mul/iu_mul.sv
// Two-stage multiplier
`timescale 1ns/100ps

module iu_mul (
  input  logic                      forever_cpuclk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic                      sel,
  input  logic [iu_pkg::FUNC_W-1:0] func,
  input  logic [iu_pkg::XLEN-1:0]   src0,
  input  logic [iu_pkg::XLEN-1:0]   src1,
  input  logic [iu_pkg::PREG_W-1:0] dst_preg,
  output iu_pkg::iu_rslt_t          mul_ex2
);

  import iu_pkg::*;

  iu_mul_op_e             op;
  logic                   signed_op;
  logic                   high_sel;
  logic [XLEN:0]          src0_ext;
  logic [XLEN:0]          src1_ext;
  logic [2*XLEN+1:0]      prod_full;
  logic [2*XLEN-1:0]      product;
  logic [XLEN-1:0]        rslt_ex1;

  assign op = iu_mul_op_e'(func);

  always_comb begin
    case (op)
      MUL_MULH: begin
        signed_op = 1'b1;
        high_sel  = 1'b1;
      end
      MUL_MULHU: begin
        signed_op = 1'b0;
        high_sel  = 1'b1;
      end
      default: begin
        signed_op = 1'b0;
        high_sel  = 1'b0;
      end
    endcase
  end

  // One extra bit so signed and unsigned share a signed multiplier
  assign src0_ext  = {signed_op & src0[XLEN-1], src0};
  assign src1_ext  = {signed_op & src1[XLEN-1], src1};
  assign prod_full = $signed(src0_ext) * $signed(src1_ext);
  assign product   = prod_full[2*XLEN-1:0];
  assign rslt_ex1  = high_sel ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

  // ex2 product register
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      mul_ex2.vld <= 1'b0;
    end else begin
      mul_ex2.vld <= sel & ~flush;
    end
    if (sel) begin
      mul_ex2.preg <= dst_preg;
      mul_ex2.data <= rslt_ex1;
    end
  end

endmodule

// File: div/iu_div.sv
// Iterative restoring divider
`timescale 1ns/100ps

module iu_div (
  input  logic                      forever_cpuclk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic                      sel,
  input  logic [iu_pkg::FUNC_W-1:0] func,
  input  logic [iu_pkg::XLEN-1:0]   src0,
  input  logic [iu_pkg::XLEN-1:0]   src1,
  input  logic [iu_pkg::PREG_W-1:0] dst_preg,
  output iu_pkg::iu_rslt_t          div_ex2,
  output logic                      div_busy
);

  import iu_pkg::*;

  iu_div_op_e           op;
  logic                 is_signed;
  logic                 s0_neg;
  logic                 s1_neg;
  logic [XLEN-1:0]      dvd_abs;
  logic [XLEN-1:0]      dvs_abs;
  logic [DIV_CNT_W-1:0] cnt_q;
  logic                 last_step;
  logic [XLEN-1:0]      acc_q;
  logic [XLEN-1:0]      quo_q;
  logic [XLEN-1:0]      dvs_q;
  logic                 q_neg_q;
  logic                 r_neg_q;
  logic                 rem_sel_q;
  logic [PREG_W-1:0]    preg_q;
  logic [XLEN:0]        part_shift;
  logic [XLEN:0]        part_diff;
  logic [XLEN:0]        acc_nxt;
  logic [XLEN-1:0]      quo_nxt;
  logic [XLEN-1:0]      quo_fix;
  logic [XLEN-1:0]      rem_fix;

  // Operand magnitudes at issue
  assign op        = iu_div_op_e'(func);
  assign is_signed = (op == DIV_DIV) | (op == DIV_REM);
  assign s0_neg    = is_signed & src0[XLEN-1];
  assign s1_neg    = is_signed & src1[XLEN-1];
  assign dvd_abs   = s0_neg ? -src0 : src0;
  assign dvs_abs   = s1_neg ? -src1 : src1;

  assign last_step = div_busy & (cnt_q == DIV_CNT_W'(DIV_STEPS - 1));

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n || flush) begin
      div_busy <= 1'b0;
      cnt_q    <= '0;
    end else if (sel) begin
      div_busy <= 1'b1;
      cnt_q    <= '0;
    end else if (div_busy) begin
      cnt_q <= cnt_q + 1'b1;
      if (last_step) begin
        div_busy <= 1'b0;
      end
    end
  end

  // A zero divisor leaves the quotient unsigned, which gives all ones
  always_ff @(posedge forever_cpuclk) begin
    if (sel) begin
      acc_q     <= '0;
      quo_q     <= dvd_abs;
      dvs_q     <= dvs_abs;
      q_neg_q   <= (s0_neg ^ s1_neg) & (src1 != '0);
      r_neg_q   <= s0_neg;
      rem_sel_q <= (op == DIV_REM) | (op == DIV_REMU);
      preg_q    <= dst_preg;
    end else if (div_busy) begin
      acc_q <= acc_nxt[XLEN-1:0];
      quo_q <= quo_nxt;
    end
  end

  // One restoring step per cycle
  always_comb begin
    part_shift = {acc_q, quo_q[XLEN-1]};
    part_diff  = part_shift - {1'b0, dvs_q};
    if (part_diff[XLEN]) begin
      acc_nxt = part_shift;
      quo_nxt = {quo_q[XLEN-2:0], 1'b0};
    end else begin
      acc_nxt = part_diff;
      quo_nxt = {quo_q[XLEN-2:0], 1'b1};
    end
  end

  // Most negative / -1 falls out as dividend and zero remainder
  assign quo_fix = q_neg_q ? -quo_nxt : quo_nxt;
  assign rem_fix = r_neg_q ? -acc_nxt[XLEN-1:0] : acc_nxt[XLEN-1:0];

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      div_ex2.vld <= 1'b0;
    end else begin
      div_ex2.vld <= last_step & ~flush;
    end
    if (last_step) begin
      div_ex2.preg <= preg_q;
      div_ex2.data <= rem_sel_q ? rem_fix : quo_fix;
    end
  end

endmodule

// File: verilog/iu_wb_ctrl.sv
// Write-back and stall control
`timescale 1ns/100ps

module iu_wb_ctrl (
  input  logic                    forever_cpuclk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  iu_pkg::iu_issue_t       issue,
  input  logic [iu_pkg::XLEN-1:0] alu_rslt,
  input  iu_pkg::iu_rslt_t        mul_ex2,
  input  iu_pkg::iu_rslt_t        div_ex2,
  input  logic                    div_busy,
  output iu_pkg::iu_rslt_t        wb,
  output iu_pkg::iu_rslt_t        ex1_fwd,
  output logic                    ex1_stall
);

  import iu_pkg::*;

  logic     alu_issue;
  logic     alu_go;
  logic     ex2_vld;
  iu_rslt_t wb_nxt;

  assign alu_issue = issue.vld & (issue.unit == UNIT_ALU);
  assign ex2_vld   = mul_ex2.vld | div_ex2.vld;

  // ex2 results own the write-back port, so a waiting ALU op holds
  assign ex1_stall = div_busy | (ex2_vld & alu_issue);
  assign alu_go    = alu_issue & ~ex1_stall & ~flush;

  always_comb begin
    ex1_fwd.vld  = alu_go;
    ex1_fwd.preg = issue.dst_preg;
    ex1_fwd.data = alu_rslt;
  end

  // Multiplier and divider never finish in the same cycle
  always_comb begin
    if (mul_ex2.vld) begin
      wb_nxt = mul_ex2;
    end else if (div_ex2.vld) begin
      wb_nxt = div_ex2;
    end else begin
      wb_nxt = ex1_fwd;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      wb.vld <= 1'b0;
    end else begin
      wb.vld <= wb_nxt.vld & ~flush;
    end
    wb.preg <= wb_nxt.preg;
    wb.data <= wb_nxt.data;
  end

endmodule

// File: verilog/iu_top.sv
// Integer execution unit top
`timescale 1ns/100ps

module iu_top (
  input  logic              forever_cpuclk,
  input  logic              rst_n,
  input  logic              flush,
  input  iu_pkg::iu_issue_t issue,
  output iu_pkg::iu_rslt_t  wb,
  output iu_pkg::iu_rslt_t  ex1_fwd,
  output logic              ex1_stall
);

  import iu_pkg::*;

  logic            issue_go;
  logic            alu_sel;
  logic            mul_sel;
  logic            div_sel;
  logic [XLEN-1:0] alu_src0;
  logic [XLEN-1:0] alu_src1;
  logic [XLEN-1:0] alu_rslt;
  iu_rslt_t        mul_ex2;
  iu_rslt_t        div_ex2;
  logic            div_busy;

  assign issue_go = issue.vld & ~ex1_stall & ~flush;
  assign alu_sel  = issue_go & (issue.unit == UNIT_ALU);
  assign mul_sel  = issue_go & (issue.unit == UNIT_MUL);
  assign div_sel  = issue_go & (issue.unit == UNIT_DIV);

  // Keep the ALU inputs quiet unless it has an op
  assign alu_src0 = alu_sel ? issue.src0 : '0;
  assign alu_src1 = alu_sel ? issue.src1 : '0;

  iu_alu u_alu (
    .func (issue.func),
    .src0 (alu_src0  ),
    .src1 (alu_src1  ),
    .rslt (alu_rslt  )
  );

  iu_mul u_mul (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .flush          (flush         ),
    .sel            (mul_sel       ),
    .func           (issue.func    ),
    .src0           (issue.src0    ),
    .src1           (issue.src1    ),
    .dst_preg       (issue.dst_preg),
    .mul_ex2        (mul_ex2       )
  );

  iu_div u_div (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .flush          (flush         ),
    .sel            (div_sel       ),
    .func           (issue.func    ),
    .src0           (issue.src0    ),
    .src1           (issue.src1    ),
    .dst_preg       (issue.dst_preg),
    .div_ex2        (div_ex2       ),
    .div_busy       (div_busy      )
  );

  iu_wb_ctrl u_wb_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .flush          (flush         ),
    .issue          (issue         ),
    .alu_rslt       (alu_rslt      ),
    .mul_ex2        (mul_ex2       ),
    .div_ex2        (div_ex2       ),
    .div_busy       (div_busy      ),
    .wb             (wb            ),
    .ex1_fwd        (ex1_fwd       ),
    .ex1_stall      (ex1_stall     )
  );

endmodule

// File: test/iu_props.sv
// Integer unit assertions
`timescale 1ns/100ps

module iu_props (
  input logic             forever_cpuclk,
  input logic             rst_n,
  input logic             flush,
  input logic             div_busy,
  input iu_pkg::iu_rslt_t wb,
  input iu_pkg::iu_rslt_t ex1_fwd,
  input logic             ex1_stall
);

  import iu_pkg::*;

  // Stall lasts up to the last divide step and busy drops after it
  stall_in_div: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n || flush)
    $rose(div_busy) && !flush |-> ##(DIV_STEPS - 1) ex1_stall ##1 !div_busy
  ) else $error("ex1_stall low before the divider finished");

  // Flush kills whatever was heading for write-back
  wb_after_flush: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n) flush |=> !wb.vld
  ) else $error("wb.vld high in the cycle after a flush");

  // A forwarded ALU result lands on wb at the next edge
  fwd_not_stalled: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n)
    ex1_fwd.vld |-> !ex1_stall ##1 (wb.vld && wb.preg == $past(ex1_fwd.preg) &&
                                    wb.data == $past(ex1_fwd.data))
  ) else $error("ex1_fwd.vld high while stalled or its result missed wb");

  reset_quiet: assert property (
    @(posedge forever_cpuclk) $rose(rst_n) |-> !wb.vld && !ex1_stall
  ) else $error("wb.vld or ex1_stall high right after reset");

endmodule

// File: test/iu_tb.sv
// Integer unit testbench
`timescale 1ns/100ps

module iu_tb;

  import iu_pkg::*;

  typedef struct packed {
    logic [1:0]        unit;
    logic [FUNC_W-1:0] func;
    logic [XLEN-1:0]   src0;
    logic [XLEN-1:0]   src1;
    logic [PREG_W-1:0] dst;
    logic              kill;
    logic [XLEN-1:0]   data;
  } rec_t;

  logic        forever_cpuclk = 1'b0;
  logic        rst_n;
  logic        flush;
  iu_issue_t   issue;
  iu_rslt_t    wb;
  iu_rslt_t    ex1_fwd;
  logic        ex1_stall;
  int          seed;
  int          errors;
  int          checks;
  int          cycle_cnt;
  int          cycle_limit;
  rec_t        recs[$];
  iu_rslt_t    exp_q[$];
  iu_rslt_t    exp_r;

  iu_top u_iu_top (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .flush          (flush         ),
    .issue          (issue         ),
    .wb             (wb            ),
    .ex1_fwd        (ex1_fwd       ),
    .ex1_stall      (ex1_stall     )
  );

  bind iu_top iu_props u_props (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .flush          (flush         ),
    .div_busy       (div_busy      ),
    .wb             (wb            ),
    .ex1_fwd        (ex1_fwd       ),
    .ex1_stall      (ex1_stall     )
  );

  always #5 forever_cpuclk = ~forever_cpuclk;

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected write-backs never arrived", exp_q.size());
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // Columns are unit func src0 src1 dst_preg flush expected, all hex
  task automatic read_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] v[7];
    rec_t        r;
    fd = $fopen("test/iu_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the stimulus file test/iu_stimulus.txt");
      finish_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
        if (n == 7) begin
          r = '{v[0][1:0], v[1][FUNC_W-1:0], v[2], v[3], v[4][PREG_W-1:0], v[5][0], v[6]};
          recs.push_back(r);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_record(input rec_t r);
    issue.vld      <= 1'b1;
    issue.unit     <= iu_unit_e'(r.unit);
    issue.func     <= r.func;
    issue.src0     <= r.src0;
    issue.src1     <= r.src1;
    issue.dst_preg <= r.dst;
  endtask

  // Returns once the next rising edge accepts the issue
  task automatic wait_accept();
    logic go;
    go = 1'b0;
    while (!go) begin
      @(negedge forever_cpuclk);
      go = !ex1_stall && !flush;
      if (!go) begin
        @(posedge forever_cpuclk);
        flush <= 1'b0;
      end
    end
  endtask

  // ALU ops show on ex1_fwd in the cycle they are accepted
  task automatic verify_forward(input rec_t r);
    if (r.unit == UNIT_ALU) begin
      check_value("ex1_fwd.vld", XLEN'(ex1_fwd.vld), XLEN'(1));
      check_value("ex1_fwd.preg", XLEN'(ex1_fwd.preg), XLEN'(r.dst));
      check_value("ex1_fwd.data", ex1_fwd.data, r.data);
    end else begin
      check_value("ex1_fwd.vld", XLEN'(ex1_fwd.vld), XLEN'(0));
    end
  endtask

  always @(posedge forever_cpuclk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      errors++;
      $display("timeout after %0d cycles with %0d write-backs missing", cycle_cnt, exp_q.size());
      finish_run();
    end
  end

  always @(negedge forever_cpuclk) begin
    if (rst_n && wb.vld) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected write-back to preg %0d at %0t", wb.preg, $time);
      end else begin
        exp_r = exp_q.pop_front();
        check_value("preg", XLEN'(wb.preg), XLEN'(exp_r.preg));
        check_value("data", wb.data, exp_r.data);
      end
    end
  end

  initial begin
    seed      = 23;
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    issue     = '0;
    read_stimulus();
    cycle_limit = recs.size() * 40 + 200;
    repeat (10) @(posedge forever_cpuclk);
    rst_n <= 1'b1;
    @(posedge forever_cpuclk);
    if (recs.size() > 0) begin
      drive_record(recs[0]);
    end
    for (int i = 0; i < recs.size(); i++) begin
      wait_accept();
      verify_forward(recs[i]);
      @(posedge forever_cpuclk);
      flush <= recs[i].kill;
      if (!recs[i].kill) begin
        exp_q.push_back(iu_rslt_t'{1'b1, recs[i].dst, recs[i].data});
      end
      if (i + 1 < recs.size()) begin
        drive_record(recs[i + 1]);
      end else begin
        issue.vld <= 1'b0;
      end
    end
    @(posedge forever_cpuclk);
    flush <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge forever_cpuclk);
    end
    // Extra cycles to catch a stray write-back
    repeat (10) @(posedge forever_cpuclk);
    finish_run();
  end

endmodule

// File: test/iu_stimulus.txt
# unit(0 alu,1 mul,2 div) func src0 src1 dst_preg flush expected_data
# all fields hex, records with flush 1 must not write back
0 0 00000005 00000007 01 0 0000000c
0 1 00000003 00000005 02 0 fffffffe
0 2 f0f0f0f0 0ff00ff0 03 0 00f000f0
0 3 12340000 00005678 04 0 12345678
0 4 ffff0000 0f0f0f0f 05 0 f0f00f0f
0 5 00000001 00000024 06 0 00000010
0 6 80000000 0000003f 07 0 00000001
0 7 80000000 00000004 08 0 f8000000
0 8 ffffffff 00000001 09 0 00000001
0 9 ffffffff 00000001 0a 0 00000000
1 0 fffffffd 00000007 0b 0 ffffffeb
1 1 fffffffe 00000003 0c 0 ffffffff
1 2 ffffffff ffffffff 0d 0 fffffffe
0 0 00000001 00000001 0e 0 00000002
2 0 ffffffec 00000006 0f 0 fffffffd
2 2 ffffffec 00000006 10 0 fffffffe
2 1 00000064 00000000 11 0 ffffffff
2 3 00000064 00000000 12 0 00000064
2 0 80000000 ffffffff 13 0 80000000
2 2 80000000 ffffffff 14 0 00000000
2 1 ffffffff 00000010 15 0 0fffffff
1 0 00000002 00000003 16 1 00000006
0 0 0000000a 00000014 17 0 0000001e
2 0 00000064 00000005 18 1 00000014
1 1 7fffffff 7fffffff 19 0 3fffffff
0 1 00000000 00000001 1a 0 ffffffff

// File: project.f
common/iu_pkg.sv
verilog/iu_alu.sv
mul/iu_mul.sv
div/iu_div.sv
verilog/iu_wb_ctrl.sv
verilog/iu_top.sv
test/iu_props.sv
test/iu_tb.sv

// File: Bender.yml
package:
  name: iu

sources:
  - common/iu_pkg.sv
  - verilog/iu_alu.sv
  - mul/iu_mul.sv
  - div/iu_div.sv
  - verilog/iu_wb_ctrl.sv
  - verilog/iu_top.sv
  - target: test
    files:
      - test/iu_props.sv
      - test/iu_tb.sv
